// ==== tests/cp0_testdata.txt ====
# id op valid exc code bd eret mtc0 mfc0 addr wdata pc badvaddr ext_int noise_mask
# then expected flush redirect rd_valid result, all hex, op 1 repeats until flush
1 0 1 0 00 0 0 1 0 58 00001000 00000000 00000000 00 00 0 00000000 0 00000000
1 0 1 0 00 0 0 1 0 70 80001230 00000000 00000000 00 00 0 00000000 0 00000000
1 0 1 0 00 0 0 1 0 60 ffffffff 00000000 00000000 00 00 0 00000000 0 00000000
1 0 1 0 00 0 0 0 1 70 00000000 00000000 00000000 00 00 0 00000000 1 80001230
1 0 1 0 00 0 0 0 1 58 00000000 00000000 00000000 00 00 0 00000000 1 00001000
1 0 1 0 00 0 0 0 1 60 00000000 00000000 00000000 00 00 0 00000000 1 0000fc03
1 0 1 0 00 0 0 0 1 7f 00000000 00000000 00000000 00 00 0 00000000 1 00000000
1 0 1 0 00 0 0 1 0 60 00000000 00000000 00000000 00 00 0 00000000 0 00000000
2 0 1 1 08 0 0 0 0 00 00000000 80000100 00000000 00 00 1 bfc00380 0 00000000
2 0 1 0 00 0 0 0 1 70 00000000 00000000 00000000 00 00 0 00000000 1 80000100
2 0 1 0 00 0 0 0 1 60 00000000 00000000 00000000 00 00 0 00000000 1 00000002
2 0 1 0 00 0 0 0 1 68 00000000 00000000 00000000 00 00 0 00000000 1 00000020
2 0 1 0 00 0 0 1 0 60 00000000 00000000 00000000 00 00 0 00000000 0 00000000
2 0 1 1 08 1 0 0 0 00 00000000 80000204 00000000 00 00 1 bfc00380 0 00000000
2 0 1 0 00 0 0 0 1 70 00000000 00000000 00000000 00 00 0 00000000 1 80000200
2 0 1 0 00 0 0 0 1 68 00000000 00000000 00000000 00 00 0 00000000 1 80000020
3 0 1 1 04 0 0 0 0 00 00000000 80000300 0000abcd 00 00 1 bfc00380 0 00000000
3 0 1 0 00 0 0 0 1 40 00000000 00000000 00000000 00 00 0 00000000 1 0000abcd
3 0 1 0 00 0 0 0 1 68 00000000 00000000 00000000 00 00 0 00000000 1 00000010
3 0 1 0 00 0 0 0 1 70 00000000 00000000 00000000 00 00 0 00000000 1 80000200
4 0 1 0 00 0 1 0 0 00 00000000 80000304 00000000 00 00 1 80000200 0 00000000
4 0 1 0 00 0 0 0 1 60 00000000 00000000 00000000 00 00 0 00000000 1 00000000
5 0 1 0 00 0 0 1 0 60 00000401 00000000 00000000 00 3e 0 00000000 0 00000000
5 0 1 0 00 0 0 0 0 00 00000000 80000400 00000000 01 3e 1 bfc00380 0 00000000
5 0 1 0 00 0 0 0 1 68 00000000 00000000 00000000 00 00 0 00000000 1 00000000
5 0 1 0 00 0 0 0 0 00 00000000 80000404 00000000 01 3e 0 00000000 0 00000000
5 0 1 0 00 0 0 1 0 60 00000001 00000000 00000000 00 00 0 00000000 0 00000000
5 0 1 0 00 0 0 0 0 00 00000000 80000408 00000000 01 3e 0 00000000 0 00000000
5 0 1 0 00 0 0 0 1 60 00000000 00000000 00000000 00 00 0 00000000 1 00000001
6 0 1 0 00 0 0 1 0 48 00000000 00000000 00000000 00 00 0 00000000 0 00000000
6 0 1 0 00 0 0 1 0 58 00000008 00000000 00000000 00 00 0 00000000 0 00000000
6 0 1 0 00 0 0 1 0 60 00008001 00000000 00000000 00 00 0 00000000 0 00000000
6 1 1 0 00 0 0 0 0 00 00000000 80000500 00000000 00 1f 1 bfc00380 0 00000000
6 0 1 0 00 0 0 0 1 68 00000000 00000000 00000000 00 00 0 00000000 1 40008000
6 0 1 0 00 0 0 1 0 58 00ff0000 00000000 00000000 00 00 0 00000000 0 00000000
6 0 1 0 00 0 0 0 1 68 00000000 00000000 00000000 00 00 0 00000000 1 00000000

// ==== vlog.f ====
verilog/cp0_pkg.sv
verilog/cp0_exc_arbiter.sv
verilog/cp0_status_cause.sv
verilog/cp0_epc_badvaddr.sv
verilog/cp0_timer.sv
verilog/cp0_result_mux.sv
verilog/cp0_top.sv
tests/cp0_sva.sv
tests/cp0_tb.sv

// ==== tests/cp0_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_tb;

    localparam cp0_pkg::word_t EXC_VECTOR = 32'hbfc0_0380;
    // requests sent while waiting for the timer flush
    localparam int MAX_TRIES = 64;

    // expected outputs of one step
    typedef struct packed {
        logic           flush;
        cp0_pkg::word_t redirect;
        logic           rd_valid;
        cp0_pkg::word_t result;
    } expect_t;

    logic              clk;
    logic              rst;
    cp0_pkg::wb_req_t  req;
    cp0_pkg::int_vec_t ext_int;
    logic              flush;
    cp0_pkg::word_t    redirect;
    cp0_pkg::word_t    result;
    logic              rd_valid;

    int errors;
    int test_errs;
    int tests;
    int steps;
    int cur_id;

    cp0_top #(
        .EXC_VECTOR (EXC_VECTOR)
    ) u_cp0_top (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .ext_int  (ext_int),
        .flush    (flush),
        .redirect (redirect),
        .result   (result),
        .rd_valid (rd_valid)
    );

    always #10 clk = ~clk;

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s in test %0d: got %h, expected %h", name, cur_id, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    // payloads only matter with their strobe
    task automatic check_outputs(input expect_t e);
        check_value("flush", flush, e.flush);
        check_value("rd_valid", rd_valid, e.rd_valid);
        if (e.flush) begin
            check_value("redirect", redirect, e.redirect);
        end
        if (e.rd_valid) begin
            check_value("result", result, e.result);
        end
    endtask

    // one-cycle request, outputs settled by the following falling edge
    task automatic send_request(input cp0_pkg::wb_req_t r, input cp0_pkg::int_vec_t lines,
                                input cp0_pkg::int_vec_t noise_mask);
        logic [31:0] rnd;
        rnd = $urandom;
        @(negedge clk);
        req     = r;
        // noise only on lines that IM keeps out
        ext_int = lines | (rnd[5:0] & noise_mask);
        @(negedge clk);
        req     = '0;
        ext_int = '0;
    endtask

    task automatic close_test();
        if (test_errs == 0) begin
            $display("test %0d: ok", cur_id);
        end else begin
            $display("test %0d: %0d errors", cur_id, test_errs);
        end
    endtask

    // op 1 repeats the request until a flush shows up
    task automatic run_step(input int id, input int op, input cp0_pkg::wb_req_t r,
                            input cp0_pkg::int_vec_t lines,
                            input cp0_pkg::int_vec_t noise_mask, input expect_t e);
        int tries;
        if (id != cur_id) begin
            if (cur_id != 0) begin
                close_test();
            end
            cur_id    = id;
            test_errs = 0;
            tests++;
        end
        steps++;
        send_request(r, lines, noise_mask);
        tries = 1;
        while (op == 1 && flush !== 1'b1 && tries < MAX_TRIES) begin
            send_request(r, lines, noise_mask);
            tries++;
        end
        if (op == 1 && flush !== 1'b1) begin
            $display("timeout in test %0d: no flush after %0d requests", id, MAX_TRIES);
            errors++;
            test_errs++;
        end else begin
            check_outputs(e);
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        int                fd;
        int                n;
        int                seed;
        int                sva_fails;
        logic [8*160-1:0]  line;
        logic [31:0]       fld [0:18];
        cp0_pkg::wb_req_t  r;
        expect_t           e;

        seed      = $urandom(32'h74f4);
        clk       = 1'b0;
        rst       = 1'b1;
        req       = '0;
        ext_int   = '0;
        errors    = 0;
        test_errs = 0;
        tests     = 0;
        steps     = 0;
        cur_id    = 0;

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        fd = $fopen("tests/cp0_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/cp0_testdata.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                n = $fgets(line, fd);
                // comment and blank lines fail to parse
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                            fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13],
                            fld[14], fld[15], fld[16], fld[17], fld[18]);
                if (n == 19) begin
                    r.valid      = fld[2][0];
                    r.exception  = fld[3][0];
                    r.exc_code   = fld[4][4:0];
                    r.bd         = fld[5][0];
                    r.eret       = fld[6][0];
                    r.mtc0       = fld[7][0];
                    r.mfc0       = fld[8][0];
                    r.addr       = fld[9][7:0];
                    r.wdata      = fld[10];
                    r.pc         = fld[11];
                    r.bad_vaddr  = fld[12];
                    e.flush      = fld[15][0];
                    e.redirect   = fld[16];
                    e.rd_valid   = fld[17][0];
                    e.result     = fld[18];
                    run_step(fld[0], fld[1], r, fld[13][5:0], fld[14][5:0], e);
                end
            end
            $fclose(fd);
            if (cur_id != 0) begin
                close_test();
            end
        end

        // bound checker failures count against the run
        sva_fails = u_cp0_top.u_cp0_sva.fail_count;
        $display("%0d tests, %0d steps, %0d errors, %0d assertion failures",
                 tests, steps, errors, sva_fails);
        if (errors == 0 && sva_fails == 0 && steps > 0) begin
            $display("test passed");
        end else begin
            if (steps == 0) begin
                $display("no test steps were read");
            end
            $display("test failed");
        end
        $finish;
    end

    // hard limit on the whole run
    initial begin
        #500_000;
        $display("timeout: run did not finish within 500 us");
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/cp0_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_sva (
    input logic           clk,
    input logic           rst,
    input logic           req_valid,
    input logic           req_eret,
    input logic           flush,
    input logic           rd_valid,
    input cp0_pkg::word_t status
);

    // number of failed assertions
    int fail_count = 0;

    // one output strobe at a time
    a_one_strobe: assert property (@(posedge clk) disable iff (rst)
        !(flush && rd_valid))
        else begin
            $error("flush and rd_valid high in the same cycle");
            fail_count++;
        end

    // flush only answers a request of the previous cycle
    a_flush_after_req: assert property (@(posedge clk) disable iff (rst)
        flush |-> $past(req_valid))
        else begin
            $error("flush without a valid request one cycle earlier");
            fail_count++;
        end

    // exception entry leaves the core at exception level
    a_exl_after_exc: assert property (@(posedge clk) disable iff (rst)
        (flush && !$past(req_eret)) |-> status[cp0_pkg::STATUS_EXL])
        else begin
            $error("Status.EXL clear after an exception flush");
            fail_count++;
        end

endmodule

bind cp0_top cp0_sva u_cp0_sva (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req.valid),
    .req_eret  (req.eret),
    .flush     (flush),
    .rd_valid  (rd_valid),
    .status    (status)
);

`default_nettype wire

// ==== verilog/cp0_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_top #(
    parameter cp0_pkg::word_t EXC_VECTOR = 32'hbfc0_0380
) (
    input  logic              clk,
    input  logic              rst,
    input  cp0_pkg::wb_req_t  req,
    input  cp0_pkg::int_vec_t ext_int,
    output logic              flush,
    output cp0_pkg::word_t    redirect,
    output cp0_pkg::word_t    result,
    output logic              rd_valid
);

    cp0_pkg::exc_ctrl_t  ctrl;
    cp0_pkg::cp0_state_t state;
    cp0_pkg::word_t      status;
    cp0_pkg::word_t      cause;
    cp0_pkg::word_t      epc;
    cp0_pkg::word_t      badvaddr;
    cp0_pkg::word_t      count;
    cp0_pkg::word_t      compare;
    logic                timer_int;

    // ------------------------------
    // register file snapshot
    // ------------------------------
    assign state = '{status: status, cause: cause, epc: epc, badvaddr: badvaddr,
                     count: count, compare: compare};

    cp0_exc_arbiter u_cp0_exc_arbiter (
        .req     (req),
        .ext_int (ext_int),
        .state   (state),
        .ctrl    (ctrl)
    );

    cp0_status_cause u_cp0_status_cause (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .ext_int   (ext_int),
        .timer_int (timer_int),
        .status    (status),
        .cause     (cause)
    );

    // epc capture gated by current exl
    cp0_epc_badvaddr u_cp0_epc_badvaddr (
        .clk      (clk),
        .rst      (rst),
        .ctrl     (ctrl),
        .exl      (status[cp0_pkg::STATUS_EXL]),
        .epc      (epc),
        .badvaddr (badvaddr)
    );

    cp0_timer u_cp0_timer (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .count     (count),
        .compare   (compare),
        .timer_int (timer_int)
    );

    cp0_result_mux #(
        .EXC_VECTOR (EXC_VECTOR)
    ) u_cp0_result_mux (
        .clk      (clk),
        .rst      (rst),
        .ctrl     (ctrl),
        .state    (state),
        .flush    (flush),
        .redirect (redirect),
        .result   (result),
        .rd_valid (rd_valid)
    );

endmodule

`default_nettype wire

// ==== verilog/cp0_result_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_result_mux #(
    parameter cp0_pkg::word_t EXC_VECTOR = 32'hbfc0_0380
) (
    input  logic                clk,
    input  logic                rst,
    input  cp0_pkg::exc_ctrl_t  ctrl,
    input  cp0_pkg::cp0_state_t state,
    output logic                flush,
    output cp0_pkg::word_t      redirect,
    output cp0_pkg::word_t      result,
    output logic                rd_valid
);

    cp0_pkg::word_t rd_data;

    // mfc0 select, unknown selector reads zero
    always_comb begin
        case (ctrl.addr)
            cp0_pkg::ADDR_STATUS:   rd_data = state.status;
            cp0_pkg::ADDR_CAUSE:    rd_data = state.cause;
            cp0_pkg::ADDR_EPC:      rd_data = state.epc;
            cp0_pkg::ADDR_BADVADDR: rd_data = state.badvaddr;
            cp0_pkg::ADDR_COUNT:    rd_data = state.count;
            cp0_pkg::ADDR_COMPARE:  rd_data = state.compare;
            default:                rd_data = '0;
        endcase
    end

    // ------------------------------
    // strobes
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            flush    <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            flush    <= ctrl.take_exc | ctrl.is_eret;
            rd_valid <= ctrl.is_read;
        end
    end

    // payload, only meaningful with its strobe
    always_ff @(posedge clk) begin
        if (ctrl.take_exc) begin
            redirect <= EXC_VECTOR;
        end else if (ctrl.is_eret) begin
            // epc before this edge
            redirect <= state.epc;
        end
        if (ctrl.is_read) begin
            result <= rd_data;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cp0_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_timer (
    input  logic               clk,
    input  logic               rst,
    input  cp0_pkg::exc_ctrl_t ctrl,
    output cp0_pkg::word_t     count,
    output cp0_pkg::word_t     compare,
    output logic               timer_int
);

    // count ticks at half the core clock
    logic half_tick;

    always_ff @(posedge clk) begin
        if (rst) begin
            half_tick <= 1'b0;
        end else begin
            half_tick <= ~half_tick;
        end
    end

    // ------------------------------
    // count / compare
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (cp0_pkg::wr_hit(ctrl, cp0_pkg::ADDR_COUNT)) begin
            count <= ctrl.wdata;
        end else if (half_tick) begin
            count <= count + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            compare <= '0;
        end else if (cp0_pkg::wr_hit(ctrl, cp0_pkg::ADDR_COMPARE)) begin
            compare <= ctrl.wdata;
        end
    end

    // sticky until compare rewritten, clear has priority
    always_ff @(posedge clk) begin
        if (rst) begin
            timer_int <= 1'b0;
        end else if (cp0_pkg::wr_hit(ctrl, cp0_pkg::ADDR_COMPARE)) begin
            timer_int <= 1'b0;
        end else if (count == compare) begin
            timer_int <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cp0_epc_badvaddr.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_epc_badvaddr (
    input  logic               clk,
    input  logic               rst,
    input  cp0_pkg::exc_ctrl_t ctrl,
    input  logic               exl,
    output cp0_pkg::word_t     epc,
    output cp0_pkg::word_t     badvaddr
);

    cp0_pkg::word_t restart_pc;
    logic           addr_err;

    // delay slot restarts at the branch
    assign restart_pc = ctrl.bd ? (ctrl.pc - 32'd4) : ctrl.pc;

    // AdEL or AdES only
    assign addr_err = (ctrl.exc_code == cp0_pkg::EXC_ADEL)
                    | (ctrl.exc_code == cp0_pkg::EXC_ADES);

    // ------------------------------
    // epc
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            epc <= '0;
        end else if (ctrl.take_exc) begin
            // nested entry keeps the first return point
            if (!exl) begin
                epc <= restart_pc;
            end
        end else if (cp0_pkg::wr_hit(ctrl, cp0_pkg::ADDR_EPC)) begin
            epc <= ctrl.wdata;
        end
    end

    // ------------------------------
    // badvaddr
    // ------------------------------
    // read-only from software
    always_ff @(posedge clk) begin
        if (rst) begin
            badvaddr <= '0;
        end else if (ctrl.take_exc && addr_err) begin
            badvaddr <= ctrl.bad_vaddr;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cp0_status_cause.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_status_cause (
    input  logic               clk,
    input  logic               rst,
    input  cp0_pkg::exc_ctrl_t ctrl,
    input  cp0_pkg::int_vec_t  ext_int,
    input  logic               timer_int,
    output cp0_pkg::word_t     status,
    output cp0_pkg::word_t     cause
);

    cp0_pkg::word_t    status_wr;
    cp0_pkg::int_vec_t ip_next;

    // only IM7..2, EXL and IE survive a write
    assign status_wr = ctrl.wdata & cp0_pkg::STATUS_WMASK;

    // timer folded onto IP7
    assign ip_next = ext_int | {timer_int, 5'b0_0000};

    // ------------------------------
    // status
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            status <= cp0_pkg::STATUS_RESET;
        end else begin
            if (ctrl.take_exc) begin
                // enter exception level
                status[cp0_pkg::STATUS_EXL] <= 1'b1;
            end else if (ctrl.is_eret) begin
                // back to user level
                status[cp0_pkg::STATUS_EXL] <= 1'b0;
            end else if (cp0_pkg::wr_hit(ctrl, cp0_pkg::ADDR_STATUS)) begin
                status <= status_wr;
            end
        end
    end

    // ------------------------------
    // cause
    // ------------------------------
    // no software-writable field here, IP1..0 not implemented
    always_ff @(posedge clk) begin
        if (rst) begin
            cause <= '0;
        end else begin
            // pending lines sampled every cycle
            cause[cp0_pkg::CAUSE_IP_HI:cp0_pkg::CAUSE_IP_LO] <= ip_next;
            cause[cp0_pkg::CAUSE_TI] <= timer_int;

            if (ctrl.take_exc) begin
                cause[cp0_pkg::CAUSE_BD] <= ctrl.bd;
                cause[cp0_pkg::CAUSE_EXC_HI:cp0_pkg::CAUSE_EXC_LO] <= ctrl.exc_code;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cp0_exc_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_exc_arbiter (
    input  cp0_pkg::wb_req_t    req,
    input  cp0_pkg::int_vec_t   ext_int,
    input  cp0_pkg::cp0_state_t state,
    output cp0_pkg::exc_ctrl_t  ctrl
);

    cp0_pkg::int_vec_t pending;
    cp0_pkg::int_vec_t im;
    logic              int_enabled;
    logic              take_int;
    logic              take_pipe_exc;
    logic              take_any;

    // ------------------------------
    // interrupt qualification
    // ------------------------------
    // timer shares IP7 with ext line 5
    assign pending = ext_int | {state.cause[cp0_pkg::CAUSE_TI], 5'b0_0000};
    assign im      = state.status[cp0_pkg::STATUS_IM_HI:cp0_pkg::STATUS_IM_LO];

    // globally on and not already in handler
    assign int_enabled = state.status[cp0_pkg::STATUS_IE]
                       & ~state.status[cp0_pkg::STATUS_EXL];

    // needs a retiring instr to attach to
    assign take_int = req.valid & int_enabled & (|(pending & im));

    assign take_pipe_exc = req.valid & req.exception;
    assign take_any      = take_int | take_pipe_exc;

    // ------------------------------
    // decision
    // ------------------------------
    always_comb begin
        ctrl.take_exc = take_any;
        // interrupt wins over the pipe's own code
        ctrl.exc_code = take_int ? cp0_pkg::EXC_INT : req.exc_code;
        ctrl.bd       = req.bd;

        // eret and cp0 accesses squashed by any exception
        ctrl.is_eret = req.valid & req.eret & ~take_any;
        ctrl.mtc0_we = req.valid & req.mtc0 & ~take_any;
        ctrl.is_read = req.valid & req.mfc0 & ~take_any;

        // payload straight through
        ctrl.addr      = req.addr;
        ctrl.wdata     = req.wdata;
        ctrl.pc        = req.pc;
        ctrl.bad_vaddr = req.bad_vaddr;
    end

endmodule

`default_nettype wire

// ==== verilog/cp0_pkg.sv ====
`default_nettype none

package cp0_pkg;

    // ------------------------------
    // basic widths
    // ------------------------------
    typedef logic [31:0] word_t;
    // {reg number, select}
    typedef logic [7:0]  cp0_addr_t;
    typedef logic [4:0]  exc_code_t;
    // hw lines, IP7..IP2
    typedef logic [5:0]  int_vec_t;

    // register selectors
    localparam cp0_addr_t ADDR_BADVADDR = 8'b01000_000;
    localparam cp0_addr_t ADDR_COUNT    = 8'b01001_000;
    localparam cp0_addr_t ADDR_COMPARE  = 8'b01011_000;
    localparam cp0_addr_t ADDR_STATUS   = 8'b01100_000;
    localparam cp0_addr_t ADDR_CAUSE    = 8'b01101_000;
    localparam cp0_addr_t ADDR_EPC      = 8'b01110_000;

    // exception codes
    localparam exc_code_t EXC_INT  = 5'h00;
    localparam exc_code_t EXC_ADEL = 5'h04;
    localparam exc_code_t EXC_ADES = 5'h05;
    localparam exc_code_t EXC_SYS  = 5'h08;
    localparam exc_code_t EXC_BP   = 5'h09;
    localparam exc_code_t EXC_RI   = 5'h0a;
    localparam exc_code_t EXC_OV   = 5'h0c;

    // ------------------------------
    // field positions
    // ------------------------------
    localparam int STATUS_IE    = 0;
    localparam int STATUS_EXL   = 1;
    localparam int STATUS_IM_LO = 10;
    localparam int STATUS_IM_HI = 15;
    localparam int CAUSE_EXC_LO = 2;
    localparam int CAUSE_EXC_HI = 6;
    localparam int CAUSE_IP_LO  = 10;
    localparam int CAUSE_IP_HI  = 15;
    localparam int CAUSE_TI     = 30;
    localparam int CAUSE_BD     = 31;

    // IM7..2, EXL, IE
    localparam word_t STATUS_WMASK = 32'h0000_fc03;
    // only EXL after reset
    localparam word_t STATUS_RESET = 32'h0000_0002;

    // retiring instruction from write-back
    typedef struct packed {
        logic      valid;
        logic      exception;
        exc_code_t exc_code;
        logic      bd;
        logic      eret;
        logic      mtc0;
        logic      mfc0;
        cp0_addr_t addr;
        word_t     wdata;
        word_t     pc;
        word_t     bad_vaddr;
    } wb_req_t;

    // arbiter decision, one per request
    typedef struct packed {
        logic      take_exc;
        exc_code_t exc_code;
        logic      bd;
        logic      is_eret;
        logic      mtc0_we;
        cp0_addr_t addr;
        word_t     wdata;
        word_t     pc;
        word_t     bad_vaddr;
        logic      is_read;
    } exc_ctrl_t;

    typedef struct packed {
        word_t status;
        word_t cause;
        word_t epc;
        word_t badvaddr;
        word_t count;
        word_t compare;
    } cp0_state_t;

    // mtc0 hitting a given register
    function automatic logic wr_hit(exc_ctrl_t c, cp0_addr_t a);
        return c.mtc0_we && (c.addr == a);
    endfunction

endpackage

`default_nettype wire
